// ==== source/dbg_pkg.sv ====
// debug window decodes only the low 12 address bits; 32-bit bus; GPR access only
package dbg_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  bus_strb_t;
  typedef logic [11:0] dbg_addr_t;
  typedef logic [19:0] hartsel_t;
  typedef logic [31:0] instr_t;

  // ------------------------------------------------------------
  // address map inside the debug window
  // ------------------------------------------------------------
  // flag writes from the parked hart
  localparam dbg_addr_t HaltedAddr      = 12'h100;
  localparam dbg_addr_t GoingAddr       = 12'h104;
  localparam dbg_addr_t ResumingAddr    = 12'h108;
  localparam dbg_addr_t ExceptionAddr   = 12'h10C;
  // variable jump word
  localparam dbg_addr_t WhereToAddr     = 12'h300;
  // ten program words, directly followed by the program buffer
  localparam dbg_addr_t AbstractCmdBase = 12'h338;
  localparam dbg_addr_t ProgBufBase     = 12'h360;
  localparam dbg_addr_t DataAddr        = 12'h380;
  // one flag byte per hart
  localparam dbg_addr_t FlagsBase       = 12'h400;
  localparam dbg_addr_t FlagsEnd        = 12'h7FF;
  // resume entry in the debug ROM, only a jump target here
  localparam dbg_addr_t ResumeAddr      = 12'h808;

  // sizes in words
  localparam int unsigned ProgBufSize      = 8;
  localparam int unsigned DataCount        = 2;
  localparam int unsigned AbstractCmdWords = 10;
  // 32-bit accesses are the widest supported
  localparam logic [2:0]  MaxAarSize       = 3'd2;

  // ------------------------------------------------------------
  // abstract commands
  // ------------------------------------------------------------
  typedef enum logic [7:0] {
    AccessRegister = 8'h0,
    QuickAccess    = 8'h1,
    AccessMemory   = 8'h2
  } cmdtype_e;

  typedef struct packed {
    cmdtype_e    cmdtype;
    logic [23:0] control;
  } cmd_t;

  // access register view of the control field
  typedef struct packed {
    logic        zero1;
    logic [2:0]  aarsize;
    logic        aarpostincrement;
    logic        postexec;
    logic        transfer;
    logic        write;
    logic [15:0] regno;
  } ac_ar_t;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4
  } cmderr_e;

  // ------------------------------------------------------------
  // structs between blocks
  // ------------------------------------------------------------
  typedef struct packed {
    logic      we;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t be;
  } bus_req_t;

  // single-cycle strobes, hartid comes from the write data
  typedef struct packed {
    logic     halted;
    logic     going;
    logic     resuming;
    logic     exception;
    hartsel_t hartid;
  } hart_event_t;

  // ------------------------------------------------------------
  // instruction encoders
  // ------------------------------------------------------------
  function automatic instr_t jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  // addi x0, x0, 0
  function automatic instr_t nop();
    return 32'h0000_0013;
  endfunction

  function automatic instr_t ebreak();
    return 32'h0010_0073;
  endfunction

  // all-zero word traps as an illegal instruction
  function automatic instr_t illegal();
    return 32'h0000_0000;
  endfunction

  function automatic instr_t load(input logic [2:0] size, input logic [4:0] dest,
                                  input logic [4:0] base, input logic [11:0] offset);
    return {offset, base, size, dest, 7'h03};
  endfunction

  function automatic instr_t store(input logic [2:0] size, input logic [4:0] src,
                                   input logic [4:0] base, input logic [11:0] offset);
    return {offset[11:5], src, base, size, offset[4:0], 7'h23};
  endfunction

endpackage

// ==== source/dbg_hart_flags.sv ====
// hart ids at or above NrHarts are ignored; masks update one cycle after the event
`timescale 1ns/1ps

module dbg_hart_flags #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dbg_pkg::hart_event_t  event_i,
  input  dbg_pkg::hartsel_t     hartsel_i,
  input  logic                  clear_resumeack_i,
  output logic [NrHarts-1:0]    halted_o,
  output logic [NrHarts-1:0]    resuming_o
);

  logic [NrHarts-1:0] halted_d, halted_q;
  logic [NrHarts-1:0] resuming_d, resuming_q;

  always_comb begin
    halted_d   = halted_q;
    resuming_d = resuming_q;
    for (int unsigned h = 0; h < NrHarts; h++) begin
      // debugger acknowledges the resume of the selected hart
      if (clear_resumeack_i && hartsel_i == dbg_pkg::hartsel_t'(h)) begin
        resuming_d[h] = 1'b0;
      end
      if (event_i.hartid == dbg_pkg::hartsel_t'(h)) begin
        // hart parked in the debug loop
        if (event_i.halted) begin
          halted_d[h] = 1'b1;
        end
        // hart left the loop, stays flagged until the debugger clears it
        if (event_i.resuming) begin
          halted_d[h]   = 1'b0;
          resuming_d[h] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      halted_q   <= '0;
      resuming_q <= '0;
    end else begin
      halted_q   <= halted_d;
      resuming_q <= resuming_d;
    end
  end

  assign halted_o   = halted_q;
  assign resuming_o = resuming_q;

endmodule

// ==== source/dbg_hart_ctrl.sv ====
// one command or resume in flight at a time; a hartsel beyond NrHarts reads as not halted
`timescale 1ns/1ps

module dbg_hart_ctrl #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dbg_pkg::hartsel_t    hartsel_i,
  input  logic [NrHarts-1:0]   haltreq_i,
  input  logic [NrHarts-1:0]   resumereq_i,
  input  logic [NrHarts-1:0]   halted_i,
  input  logic [NrHarts-1:0]   resuming_i,
  input  dbg_pkg::hart_event_t event_i,
  input  logic                 cmd_valid_i,
  input  logic                 unsupported_i,
  output logic                 go_o,
  output logic                 resume_o,
  output logic                 cmdbusy_o,
  output logic                 cmderror_valid_o,
  output dbg_pkg::cmderr_e     cmderror_o
);

  typedef enum logic [1:0] {
    Idle,
    Go,
    Resume,
    Executing
  } state_e;

  state_e state_d, state_q;
  logic   sel_halted, sel_resuming, sel_haltreq, sel_resumereq;

  // per-hart bits of the selected hart
  always_comb begin
    sel_halted    = 1'b0;
    sel_resuming  = 1'b0;
    sel_haltreq   = 1'b0;
    sel_resumereq = 1'b0;
    for (int unsigned h = 0; h < NrHarts; h++) begin
      if (hartsel_i == dbg_pkg::hartsel_t'(h)) begin
        sel_halted    = halted_i[h];
        sel_resuming  = resuming_i[h];
        sel_haltreq   = haltreq_i[h];
        sel_resumereq = resumereq_i[h];
      end
    end
  end

  always_comb begin
    state_d          = state_q;
    cmderror_valid_o = 1'b0;
    cmderror_o       = dbg_pkg::CmdErrNone;
    unique case (state_q)
      Idle: begin
        if (cmd_valid_i && sel_halted && !unsupported_i) begin
          state_d = Go;
        end else if (cmd_valid_i) begin
          // commands need a halted hart
          cmderror_valid_o = 1'b1;
          cmderror_o       = dbg_pkg::CmdErrHaltResume;
        end
        // resume only when no halt is pending and the last ack was cleared
        if (sel_resumereq && sel_halted && !sel_haltreq && !sel_resuming) begin
          state_d = Resume;
        end
      end
      // hart polls go, then reports going
      Go:        if (event_i.going) state_d = Executing;
      // done once the hart is back in the park loop
      Executing: if (event_i.halted && event_i.hartid == hartsel_i) state_d = Idle;
      Resume:    if (sel_resuming) state_d = Idle;
      default:   state_d = Idle;
    endcase

    // not-supported beats the halt/resume error
    if (cmd_valid_i && unsupported_i) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_pkg::CmdErrNotSupported;
    end
    // exception beats everything
    if (event_i.exception) begin
      cmderror_valid_o = 1'b1;
      cmderror_o       = dbg_pkg::CmdErrException;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign go_o      = (state_q == Go);
  assign resume_o  = (state_q == Resume);
  assign cmdbusy_o = (state_q != Idle);

endmodule

// ==== source/dbg_abstract_cmd.sv ====
// access register to GPRs only, 32-bit max, x0 as load/store base, no postincrement
`timescale 1ns/1ps

module dbg_abstract_cmd (
  input  dbg_pkg::cmd_t                                  cmd_i,
  output dbg_pkg::instr_t [dbg_pkg::AbstractCmdWords-1:0] prog_o,
  output logic                                           unsupported_o
);

  dbg_pkg::ac_ar_t ac_ar;
  logic            bad_regno;

  assign ac_ar = dbg_pkg::ac_ar_t'(cmd_i.control);

  // reserved range or CSR space, only checked for a transfer
  assign bad_regno = ac_ar.transfer && (ac_ar.regno[15:14] != 2'b00 || !ac_ar.regno[12]);

  always_comb begin
    // default program does nothing and returns to the park loop
    for (int unsigned w = 0; w < dbg_pkg::AbstractCmdWords; w++) begin
      prog_o[w] = dbg_pkg::nop();
    end
    prog_o[dbg_pkg::AbstractCmdWords-1] = dbg_pkg::ebreak();

    unsupported_o = (cmd_i.cmdtype != dbg_pkg::AccessRegister) ||
                    (ac_ar.aarsize > dbg_pkg::MaxAarSize) ||
                    ac_ar.aarpostincrement || bad_regno;

    // ------------------------------------------------------------
    // register transfer through the first data word
    // ------------------------------------------------------------
    if (unsupported_o) begin
      // leave immediately
      prog_o[0] = dbg_pkg::ebreak();
    end else if (ac_ar.transfer) begin
      if (ac_ar.write) begin
        // data register into the GPR
        prog_o[0] = dbg_pkg::load(ac_ar.aarsize, ac_ar.regno[4:0], 5'd0, dbg_pkg::DataAddr);
      end else begin
        // GPR into the data register
        prog_o[0] = dbg_pkg::store(ac_ar.aarsize, ac_ar.regno[4:0], 5'd0, dbg_pkg::DataAddr);
      end
    end

    // drop the final ebreak so execution runs on into the program buffer
    if (ac_ar.postexec && !unsupported_o) begin
      prog_o[dbg_pkg::AbstractCmdWords-1] = dbg_pkg::nop();
    end
  end

endmodule

// ==== source/dbg_mem_map.sv ====
// no stall; read data one cycle later; where-to resume check always looks at hart 0
`timescale 1ns/1ps

module dbg_mem_map #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            req_i,
  input  dbg_pkg::bus_req_t                               bus_req_i,
  output dbg_pkg::bus_data_t                              rdata_o,
  input  dbg_pkg::hartsel_t                               hartsel_i,
  input  logic [NrHarts-1:0]                              resumereq_i,
  input  logic                                            go_i,
  input  logic                                            resume_i,
  input  logic                                            cmdbusy_i,
  input  dbg_pkg::cmd_t                                   cmd_i,
  input  dbg_pkg::instr_t [dbg_pkg::AbstractCmdWords-1:0] prog_i,
  input  dbg_pkg::bus_data_t [dbg_pkg::ProgBufSize-1:0]   progbuf_i,
  input  dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]     data_i,
  output dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]     data_o,
  output logic                                            data_valid_o,
  output dbg_pkg::hart_event_t                            event_o
);

  // last byte of each region
  localparam dbg_pkg::dbg_addr_t DataEnd =
      dbg_pkg::DataAddr + dbg_pkg::dbg_addr_t'(4 * dbg_pkg::DataCount - 1);
  localparam dbg_pkg::dbg_addr_t ProgBufEnd =
      dbg_pkg::ProgBufBase + dbg_pkg::dbg_addr_t'(4 * dbg_pkg::ProgBufSize - 1);
  localparam dbg_pkg::dbg_addr_t AbstractCmdEnd =
      dbg_pkg::AbstractCmdBase + dbg_pkg::dbg_addr_t'(4 * dbg_pkg::AbstractCmdWords - 1);

  localparam int unsigned DataIdxW = $clog2(dbg_pkg::DataCount);
  localparam int unsigned PbufIdxW = $clog2(dbg_pkg::ProgBufSize);
  localparam int unsigned ProgIdxW = $clog2(dbg_pkg::AbstractCmdWords);

  dbg_pkg::dbg_addr_t addr;
  dbg_pkg::ac_ar_t    ac_ar;
  logic [DataIdxW-1:0] data_idx;
  logic [PbufIdxW-1:0] pbuf_idx;
  logic [ProgIdxW-1:0] prog_idx;
  logic [9:0]          flag_word;
  logic [3:0][7:0]     flags;
  dbg_pkg::bus_data_t  rdata_d, rdata_q;

  assign addr  = bus_req_i.addr[11:0];
  assign ac_ar = dbg_pkg::ac_ar_t'(cmd_i.control);

  // word index inside each region
  assign data_idx  = DataIdxW'((addr - dbg_pkg::DataAddr) >> 2);
  assign pbuf_idx  = PbufIdxW'((addr - dbg_pkg::ProgBufBase) >> 2);
  assign prog_idx  = ProgIdxW'((addr - dbg_pkg::AbstractCmdBase) >> 2);
  assign flag_word = 10'((addr - dbg_pkg::FlagsBase) >> 2);

  // ------------------------------------------------------------
  // writes: hart events and data registers
  // ------------------------------------------------------------
  always_comb begin
    event_o        = '0;
    event_o.hartid = bus_req_i.wdata[19:0];
    data_o         = data_i;
    data_valid_o   = 1'b0;
    if (req_i && bus_req_i.we) begin
      case (addr) inside
        dbg_pkg::HaltedAddr:    event_o.halted    = 1'b1;
        dbg_pkg::GoingAddr:     event_o.going     = 1'b1;
        dbg_pkg::ResumingAddr:  event_o.resuming  = 1'b1;
        dbg_pkg::ExceptionAddr: event_o.exception = 1'b1;
        [dbg_pkg::DataAddr:DataEnd]: begin
          // byte merge over the debugger's copy
          data_valid_o = 1'b1;
          for (int b = 0; b < 4; b++) begin
            if (bus_req_i.be[b]) begin
              data_o[data_idx][b*8 +: 8] = bus_req_i.wdata[b*8 +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // reads
  // ------------------------------------------------------------
  always_comb begin
    // unmapped reads and all writes return the zero word
    rdata_d = dbg_pkg::illegal();
    flags   = '0;
    if (req_i && !bus_req_i.we) begin
      case (addr) inside
        dbg_pkg::WhereToAddr: begin
          if (resumereq_i[0]) begin
            rdata_d = dbg_pkg::jal(5'd0,
                21'(dbg_pkg::ResumeAddr) - 21'(dbg_pkg::WhereToAddr));
          end
          // a pending command wins over resume
          if (cmdbusy_i) begin
            // postexec without transfer goes straight to the program buffer
            if (cmd_i.cmdtype == dbg_pkg::AccessRegister && ac_ar.postexec &&
                !ac_ar.transfer) begin
              rdata_d = dbg_pkg::jal(5'd0,
                  21'(dbg_pkg::ProgBufBase) - 21'(dbg_pkg::WhereToAddr));
            end else begin
              rdata_d = dbg_pkg::jal(5'd0,
                  21'(dbg_pkg::AbstractCmdBase) - 21'(dbg_pkg::WhereToAddr));
            end
          end
        end
        [dbg_pkg::DataAddr:DataEnd]:               rdata_d = data_i[data_idx];
        [dbg_pkg::ProgBufBase:ProgBufEnd]:         rdata_d = progbuf_i[pbuf_idx];
        [dbg_pkg::AbstractCmdBase:AbstractCmdEnd]: rdata_d = prog_i[prog_idx];
        [dbg_pkg::FlagsBase:dbg_pkg::FlagsEnd]: begin
          // four harts per word, the polling hart sees its own lane
          if ({8'b0, flag_word} == hartsel_i[19:2]) begin
            flags[hartsel_i[1:0]] = {6'b0, resume_i, go_i};
          end
          rdata_d = flags;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== source/dbg_mem.sv ====
// NrHarts 1 to 32; hart bus never stalls; no debug ROM inside this block
`timescale 1ns/1ps

module dbg_mem #(
  parameter int unsigned NrHarts = 1
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  output logic [NrHarts-1:0]                            debug_req_o,
  // debugger side
  input  dbg_pkg::hartsel_t                             hartsel_i,
  input  logic [NrHarts-1:0]                            haltreq_i,
  input  logic [NrHarts-1:0]                            resumereq_i,
  input  logic                                          clear_resumeack_i,
  output logic [NrHarts-1:0]                            halted_o,
  output logic [NrHarts-1:0]                            resuming_o,
  input  dbg_pkg::bus_data_t [dbg_pkg::ProgBufSize-1:0] progbuf_i,
  input  dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]   data_i,
  output dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]   data_o,
  output logic                                          data_valid_o,
  input  logic                                          cmd_valid_i,
  input  dbg_pkg::cmd_t                                 cmd_i,
  output logic                                          cmderror_valid_o,
  output dbg_pkg::cmderr_e                              cmderror_o,
  output logic                                          cmdbusy_o,
  // hart bus
  input  logic                                          req_i,
  input  dbg_pkg::bus_req_t                             bus_req_i,
  output dbg_pkg::bus_data_t                            rdata_o
);

  dbg_pkg::hart_event_t                            hart_event;
  dbg_pkg::instr_t [dbg_pkg::AbstractCmdWords-1:0] prog;
  logic                                            unsupported, go, resume;

  // halt request goes straight to the harts
  assign debug_req_o = haltreq_i;

  dbg_hart_flags #(.NrHarts(NrHarts)) i_flags (
    .clk_i, .rst_ni,
    .event_i           (hart_event),
    .hartsel_i, .clear_resumeack_i,
    .halted_o, .resuming_o
  );

  dbg_hart_ctrl #(.NrHarts(NrHarts)) i_ctrl (
    .clk_i, .rst_ni, .hartsel_i, .haltreq_i, .resumereq_i,
    .halted_i      (halted_o),
    .resuming_i    (resuming_o),
    .event_i       (hart_event),
    .cmd_valid_i,
    .unsupported_i (unsupported),
    .go_o          (go),
    .resume_o      (resume),
    .cmdbusy_o, .cmderror_valid_o, .cmderror_o
  );

  dbg_abstract_cmd i_abstract_cmd (
    .cmd_i,
    .prog_o        (prog),
    .unsupported_o (unsupported)
  );

  dbg_mem_map #(.NrHarts(NrHarts)) i_mem_map (
    .clk_i, .rst_ni, .req_i, .bus_req_i, .rdata_o, .hartsel_i, .resumereq_i,
    .go_i      (go),
    .resume_i  (resume),
    .cmdbusy_i (cmdbusy_o),
    .cmd_i,
    .prog_i    (prog),
    .progbuf_i, .data_i, .data_o, .data_valid_o,
    .event_o   (hart_event)
  );

endmodule

// ==== verif/dbg_mem_tb.sv ====
// two harts, one directed sequence of one-cycle steps; stops at the first mismatch
`timescale 1ns/1ps

module dbg_mem_tb;

  localparam int unsigned NrHarts = 2;

  // abstract commands used by the sequence
  localparam dbg_pkg::cmd_t CmdGprRd  = 32'h0022_1005;
  localparam dbg_pkg::cmd_t CmdMemory = 32'h0222_1005;
  localparam dbg_pkg::cmd_t CmdSize64 = 32'h0032_1005;
  localparam dbg_pkg::cmd_t CmdCsr    = 32'h0022_0300;

  // one step is one clock cycle on the hart bus or debugger side
  typedef enum logic [2:0] {
    OpIdle,
    OpRead,
    OpWrite,
    OpDataWr,
    OpCmd,
    OpClear
  } op_e;

  typedef struct packed {
    op_e                op;
    dbg_pkg::dbg_addr_t addr;
    dbg_pkg::bus_data_t wdata;
    dbg_pkg::bus_strb_t be;
    dbg_pkg::hartsel_t  hartsel;
    logic [NrHarts-1:0] resumereq;
    logic [NrHarts-1:0] haltreq;
    dbg_pkg::cmd_t      cmd;
    dbg_pkg::cmderr_e   exp_err;
    logic [NrHarts-1:0] exp_halted;
    logic [NrHarts-1:0] exp_resuming;
    logic               exp_busy;
    // rdata for reads, data_o[0] for data writes
    dbg_pkg::bus_data_t exp_word;
  } step_t;

  logic                                          clk;
  logic                                          rst_n;
  logic [NrHarts-1:0]                            debug_req;
  dbg_pkg::hartsel_t                             hartsel;
  logic [NrHarts-1:0]                            haltreq;
  logic [NrHarts-1:0]                            resumereq;
  logic                                          clear_resumeack;
  logic [NrHarts-1:0]                            halted;
  logic [NrHarts-1:0]                            resuming;
  dbg_pkg::bus_data_t [dbg_pkg::ProgBufSize-1:0] progbuf;
  dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]   data_in;
  dbg_pkg::bus_data_t [dbg_pkg::DataCount-1:0]   data_out;
  logic                                          data_valid;
  logic                                          cmd_valid;
  dbg_pkg::cmd_t                                 cmd;
  logic                                          cmderror_valid;
  dbg_pkg::cmderr_e                              cmderror;
  logic                                          cmdbusy;
  logic                                          req;
  dbg_pkg::bus_req_t                             bus_req;
  dbg_pkg::bus_data_t                            rdata;

  step_t  steps[$];
  int     step_idx;
  int     cycles;
  int     cycle_limit;
  integer seed;

  dbg_mem #(.NrHarts(NrHarts)) dut_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .debug_req_o       (debug_req),
    .hartsel_i         (hartsel),
    .haltreq_i         (haltreq),
    .resumereq_i       (resumereq),
    .clear_resumeack_i (clear_resumeack),
    .halted_o          (halted),
    .resuming_o        (resuming),
    .progbuf_i         (progbuf),
    .data_i            (data_in),
    .data_o            (data_out),
    .data_valid_o      (data_valid),
    .cmd_valid_i       (cmd_valid),
    .cmd_i             (cmd),
    .cmderror_valid_o  (cmderror_valid),
    .cmderror_o        (cmderror),
    .cmdbusy_o         (cmdbusy),
    .req_i             (req),
    .bus_req_i         (bus_req),
    .rdata_o           (rdata)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit, scaled to the table length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles, the sequence did not finish", cycles));
    end
  end

  // ------------------------------------------------------------
  // failure and compare tasks
  // ------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_data(input string name, input dbg_pkg::bus_data_t got,
                            input dbg_pkg::bus_data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h, expected %h at step %0d",
                         name, got, exp, step_idx));
    end
  endtask

  task automatic check_mask(input string name, input logic [NrHarts-1:0] got,
                            input logic [NrHarts-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h, expected %h at step %0d",
                         name, got, exp, step_idx));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h, expected %h at step %0d",
                         name, got, exp, step_idx));
    end
  endtask

  // an expected CmdErrNone means no error strobe at all
  task automatic check_err(input logic got_valid, input dbg_pkg::cmderr_e got,
                           input dbg_pkg::cmderr_e exp);
    logic exp_valid;
    exp_valid = (exp != dbg_pkg::CmdErrNone);
    if (got_valid !== exp_valid) begin
      fail_run($sformatf("error cmderror_valid_o: got %h, expected %h at step %0d",
                         got_valid, exp_valid, step_idx));
    end else if (exp_valid && got !== exp) begin
      fail_run($sformatf("error cmderror_o: got %h, expected %h at step %0d",
                         got, exp, step_idx));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------
  task automatic add_step(input op_e op, input dbg_pkg::dbg_addr_t addr,
                          input dbg_pkg::bus_data_t wdata, input dbg_pkg::bus_strb_t be,
                          input dbg_pkg::hartsel_t hsel, input logic [NrHarts-1:0] rreq,
                          input logic [NrHarts-1:0] hreq,
                          input dbg_pkg::cmd_t c, input dbg_pkg::cmderr_e err,
                          input logic [NrHarts-1:0] hlt, input logic [NrHarts-1:0] rsm,
                          input logic busy, input dbg_pkg::bus_data_t word);
    step_t s;
    s.op           = op;
    s.addr         = addr;
    s.wdata        = wdata;
    s.be           = be;
    s.hartsel      = hsel;
    s.resumereq    = rreq;
    s.haltreq      = hreq;
    s.cmd          = c;
    s.exp_err      = err;
    s.exp_halted   = hlt;
    s.exp_resuming = rsm;
    s.exp_busy     = busy;
    s.exp_word     = word;
    steps.push_back(s);
  endtask

  task automatic build_table();
    // hart 1 parks on request, then a command to unhalted hart 0 is refused
    add_step(OpWrite, dbg_pkg::HaltedAddr, 32'h1, 4'hf, 20'd1, 2'b00, 2'b10,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, 32'h0);
    add_step(OpCmd, 12'h0, 32'h0, 4'hf, 20'd0, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrHaltResume, 2'b10, 2'b00, 1'b0, 32'h0);
    // read x5 on hart 1: go flag in lane 1, jump into the program, sw x5, 0x380(x0)
    add_step(OpCmd, 12'h0, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h0);
    add_step(OpRead, dbg_pkg::FlagsBase, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h0000_0100);
    add_step(OpRead, dbg_pkg::WhereToAddr, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h0380_006F);
    add_step(OpRead, dbg_pkg::AbstractCmdBase, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h3850_2023);
    // last program word stays ebreak without postexec
    add_step(OpRead, dbg_pkg::AbstractCmdBase + 12'h24, 32'h0, 4'hf, 20'd1, 2'b00,
             2'b00, CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h0010_0073);
    add_step(OpWrite, dbg_pkg::GoingAddr, 32'h1, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b1, 32'h0);
    add_step(OpWrite, dbg_pkg::HaltedAddr, 32'h1, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, 32'h0);
    // unsupported commands never start
    add_step(OpCmd, 12'h0, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdMemory, dbg_pkg::CmdErrNotSupported, 2'b10, 2'b00, 1'b0, 32'h0);
    add_step(OpCmd, 12'h0, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdSize64, dbg_pkg::CmdErrNotSupported, 2'b10, 2'b00, 1'b0, 32'h0);
    add_step(OpCmd, 12'h0, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdCsr, dbg_pkg::CmdErrNotSupported, 2'b10, 2'b00, 1'b0, 32'h0);
    add_step(OpWrite, dbg_pkg::ExceptionAddr, 32'h1, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrException, 2'b10, 2'b00, 1'b0, 32'h0);
    // bytes 0 and 2 taken from the bus, 1 and 3 from data_i
    add_step(OpDataWr, dbg_pkg::DataAddr, 32'hAABB_CCDD, 4'b0101, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, 32'h11BB_33DD);
    add_step(OpRead, dbg_pkg::DataAddr + 12'h4, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, data_in[1]);
    add_step(OpRead, dbg_pkg::ProgBufBase, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, progbuf[0]);
    add_step(OpRead, dbg_pkg::ProgBufBase + 12'h1C, 32'h0, 4'hf, 20'd1, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, progbuf[7]);
    // resume of hart 0, held back while a halt request is pending
    add_step(OpWrite, dbg_pkg::HaltedAddr, 32'h0, 4'hf, 20'd0, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b11, 2'b00, 1'b0, 32'h0);
    add_step(OpIdle, 12'h0, 32'h0, 4'hf, 20'd0, 2'b01, 2'b01,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b11, 2'b00, 1'b0, 32'h0);
    // where-to read in the cycle the request is taken
    add_step(OpRead, dbg_pkg::WhereToAddr, 32'h0, 4'hf, 20'd0, 2'b01, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b11, 2'b00, 1'b1, 32'h5080_006F);
    add_step(OpRead, dbg_pkg::FlagsBase, 32'h0, 4'hf, 20'd0, 2'b01, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b11, 2'b00, 1'b1, 32'h0000_0002);
    add_step(OpWrite, dbg_pkg::ResumingAddr, 32'h0, 4'hf, 20'd0, 2'b01, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b01, 1'b1, 32'h0);
    add_step(OpIdle, 12'h0, 32'h0, 4'hf, 20'd0, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b01, 1'b0, 32'h0);
    add_step(OpClear, 12'h0, 32'h0, 4'hf, 20'd0, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, 32'h0);
    add_step(OpIdle, 12'h0, 32'h0, 4'hf, 20'd0, 2'b00, 2'b00,
             CmdGprRd, dbg_pkg::CmdErrNone, 2'b10, 2'b00, 1'b0, 32'h0);
  endtask

  // ------------------------------------------------------------
  // one step: drive at edge + 2, combinational checks at edge + 8,
  // registered checks 1 ns after the next edge
  // ------------------------------------------------------------
  task automatic apply_step(input step_t s);
    dbg_pkg::bus_data_t exp_rdata;
    req             = (s.op == OpRead) || (s.op == OpWrite) || (s.op == OpDataWr);
    bus_req.we      = (s.op != OpRead);
    bus_req.addr    = dbg_pkg::bus_addr_t'(s.addr);
    bus_req.wdata   = s.wdata;
    bus_req.be      = s.be;
    hartsel         = s.hartsel;
    resumereq       = s.resumereq;
    haltreq         = s.haltreq;
    cmd             = s.cmd;
    cmd_valid       = (s.op == OpCmd);
    clear_resumeack = (s.op == OpClear);
    #6;
    check_err(cmderror_valid, cmderror, s.exp_err);
    check_flag("data_valid_o", data_valid, s.op == OpDataWr);
    // halt requests pass straight through to the harts
    check_mask("debug_req_o", debug_req, s.haltreq);
    if (s.op == OpDataWr) begin
      check_data("data_o[0]", data_out[0], s.exp_word);
      // the other data word keeps the debugger's copy
      check_data("data_o[1]", data_out[1], 32'h5566_7788);
    end
    // writes and idle cycles return the zero word
    exp_rdata = (s.op == OpRead) ? s.exp_word : 32'h0;
    @(posedge clk);
    #1;
    check_mask("halted_o", halted, s.exp_halted);
    check_mask("resuming_o", resuming, s.exp_resuming);
    check_flag("cmdbusy_o", cmdbusy, s.exp_busy);
    check_data("rdata_o", rdata, exp_rdata);
    #1;
  endtask

  initial begin
    cycles   = 0;
    step_idx = -1;
    seed     = 32'he84f_a56f;
    for (int i = 0; i < dbg_pkg::ProgBufSize; i++) begin
      progbuf[i] = $random(seed);
    end
    data_in[0] = 32'h1122_3344;
    data_in[1] = 32'h5566_7788;
    build_table();
    cycle_limit = 2 * steps.size() + 100;

    rst_n           = 1'b0;
    hartsel         = '0;
    haltreq         = '0;
    resumereq       = '0;
    clear_resumeack = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = CmdGprRd;
    req             = 1'b0;
    bus_req         = '0;

    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // reset state
    check_mask("halted_o", halted, 2'b00);
    check_mask("resuming_o", resuming, 2'b00);
    check_flag("cmdbusy_o", cmdbusy, 1'b0);
    check_flag("cmderror_valid_o", cmderror_valid, 1'b0);
    check_data("rdata_o", rdata, 32'h0);

    for (int i = 0; i < steps.size(); i++) begin
      step_idx = i;
      apply_step(steps[i]);
    end
    $display("sim passed");
    $finish;
  end

endmodule

// ==== dbg_mem.f ====
source/dbg_pkg.sv
source/dbg_hart_flags.sv
source/dbg_hart_ctrl.sv
source/dbg_abstract_cmd.sv
source/dbg_mem_map.sv
source/dbg_mem.sv
verif/dbg_mem_tb.sv

// ==== Bender.yml ====
package:
  name: dbg_mem

sources:
  - source/dbg_pkg.sv
  - source/dbg_hart_flags.sv
  - source/dbg_hart_ctrl.sv
  - source/dbg_abstract_cmd.sv
  - source/dbg_mem_map.sv
  - source/dbg_mem.sv
  - target: simulation
    files:
      - verif/dbg_mem_tb.sv
